//--- Makefile
# Verilator build and run of the back-end testbench

TOP := pj_backend_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- all.f
+incdir+include
hw/pj_reg_pkg.sv
hw/pj_op_pkg.sv
hw/op_queue.sv
hw/arch_state.sv
hw/issue_unit.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/pj_backend.sv
bench/pj_backend_checker.sv
bench/pj_backend_tb.sv

//--- bench/pj_backend_checker.sv
`timescale 1ns/1ps
`include "pj_cfg.svh"

module pj_backend_checker
  (input  logic                                   clk_i
   , input  logic                                 reset_i
   , input  logic                                 push_i
   , input  pj_op_pkg::renamed_op_t               op_i
   , input  logic                                 full_i
   , input  logic                                 rob_flag_i
   , input  pj_reg_pkg::flag_write_t              rob_flag_write_i
   , input  pj_op_pkg::wb_t [`PJ_NUM_FU-1:0]      wb_i
   , output logic [`PJ_NUM_FU-1:0]                wb_known_o
   , output pj_reg_pkg::word_t [`PJ_NUM_FU-1:0]   wb_exp_data_o
   , output pj_reg_pkg::flags_t                   model_flags_o
   , output int                                   outstanding_o
   , output logic                                 full_exp_o
   , output logic                                 full_obs_o
   );

  localparam int NUM_REG = `PJ_NUM_PHYS_REG;
  localparam int NUM_FU  = `PJ_NUM_FU;

  // model value of each tag, as of the latest pushed producer
  pj_reg_pkg::word_t model_q [NUM_REG];
  logic              pending_q [NUM_REG];
  int                port_q [NUM_REG];
  pj_reg_pkg::flags_t flags_q;
  int                outstanding_q;

  // pop, push and full_o history, bit k is k edges back
  logic [3:0]        pop_hist_q;
  logic [3:0]        push_hist_q;
  logic [2:0]        full_hist_q;
  int                q_count_q;
  logic              full_exp_q;
  logic              full_obs_q;

  function automatic pj_reg_pkg::word_t expected_result(pj_op_pkg::alu_op_e op,
    pj_reg_pkg::word_t a, pj_reg_pkg::word_t b, pj_reg_pkg::word_t imm);
    logic [63:0] prod;
    prod = 64'(a) * 64'(b);
    case (op)
      pj_op_pkg::OP_ADD:  return a + b;
      pj_op_pkg::OP_SUB:  return a - b;
      pj_op_pkg::OP_AND:  return a & b;
      pj_op_pkg::OP_OR:   return a | b;
      pj_op_pkg::OP_ADDI: return a + imm;
      default:            return prod[31:0];
    endcase
  endfunction

  always @(posedge clk_i)
  begin : update
    int         nwb;
    logic [4:0] pops;
    logic [4:0] pushes;
    logic [3:0] fulls;
    int         count_n;
    nwb = 0;
    if (reset_i)
    begin
      for (int t = 0; t < NUM_REG; t++)
      begin
        model_q[t]   <= '0;
        pending_q[t] <= 1'b0;
      end
      flags_q       <= '0;
      outstanding_q <= 0;
      pop_hist_q    <= '0;
      push_hist_q   <= '0;
      full_hist_q   <= '0;
      q_count_q     <= 0;
      full_exp_q    <= 1'b0;
      full_obs_q    <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < NUM_FU; i++)
      begin
        if (wb_i[i].valid)
        begin
          pending_q[wb_i[i].tag] <= 1'b0;
          nwb = nwb + 1;
        end
      end
      if (push_i)
      begin
        model_q[op_i.dst]   <= expected_result(op_i.op, model_q[op_i.src1],
                                               model_q[op_i.src2], op_i.imm);
        pending_q[op_i.dst] <= 1'b1;
        port_q[op_i.dst]    <= (op_i.op == pj_op_pkg::OP_MUL) ? 1 : 0;
      end
      // keep_mask bit set holds the old flag
      if (rob_flag_i)
      begin
        for (int k = 0; k < `PJ_NUM_FLAGS; k++)
          flags_q[k] <= rob_flag_write_i.keep_mask[k] ? flags_q[k]
                                                      : rob_flag_write_i.value[k];
      end
      outstanding_q <= outstanding_q + (push_i ? 1 : 0) - nwb;

      // a pop shows as a write-back two edges later from the alu, four from the multiplier
      pops    = {pop_hist_q, 1'b0};
      pops[2] = pops[2] | wb_i[0].valid;
      pops[4] = pops[4] | wb_i[1].valid;
      pushes  = {push_hist_q, push_i};
      fulls   = {full_hist_q, full_i};
      // queue count four edges back, every pop up to then is known by now
      count_n = q_count_q + int'(pushes[4]) - int'(pops[4]);
      pop_hist_q  <= pops[3:0];
      push_hist_q <= pushes[3:0];
      full_hist_q <= fulls[2:0];
      q_count_q   <= count_n;
      full_exp_q  <= (count_n == `PJ_IQ_DEPTH);
      full_obs_q  <= fulls[3];
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_FU; i++)
    begin
      wb_known_o[i]    = pending_q[wb_i[i].tag] && (port_q[wb_i[i].tag] == i);
      wb_exp_data_o[i] = model_q[wb_i[i].tag];
    end
  end

  assign model_flags_o = flags_q;
  assign outstanding_o = outstanding_q;
  assign full_exp_o    = full_exp_q;
  assign full_obs_o    = full_obs_q;

endmodule

//--- bench/pj_backend_tb.sv
`timescale 1ns/1ps
`include "pj_cfg.svh"

module pj_backend_tb;

  localparam int NUM_FU        = `PJ_NUM_FU;
  localparam int ROUNDS        = 10;
  localparam int OPS_PER_ROUND = 8;
  localparam int DIRECTED_OPS  = 13;
  // 40 cycles for every pushed op
  localparam int CYCLE_LIMIT   = 40 * (DIRECTED_OPS + ROUNDS * OPS_PER_ROUND);

  logic                                clk_i;
  logic                                reset_i;
  logic                                push_i;
  pj_op_pkg::renamed_op_t              op_i;
  logic                                full_o;
  logic                                rob_free_i;
  pj_reg_pkg::phys_tag_t               rob_free_tag_i;
  logic                                rob_flag_i;
  pj_reg_pkg::flag_write_t             rob_flag_write_i;
  pj_reg_pkg::flags_t                  flags_o;
  pj_op_pkg::wb_t [NUM_FU-1:0]         wb_o;

  logic [NUM_FU-1:0]                   wb_known;
  pj_reg_pkg::word_t [NUM_FU-1:0]      wb_exp_data;
  pj_reg_pkg::flags_t                  model_flags;
  int                                  outstanding;
  logic                                full_exp;
  logic                                full_obs;

  integer                              seed;
  string                               test_name;
  int                                  cycle_count;
  logic                                saw_full;
  pj_reg_pkg::phys_tag_t               free_q[$];
  pj_reg_pkg::phys_tag_t               known_q[$];
  pj_reg_pkg::phys_tag_t               alloc_q[$];

  pj_backend i_pj_backend
    (.clk_i(clk_i), .reset_i(reset_i)
     , .push_i(push_i), .op_i(op_i), .full_o(full_o)
     , .rob_free_i(rob_free_i), .rob_free_tag_i(rob_free_tag_i)
     , .rob_flag_i(rob_flag_i), .rob_flag_write_i(rob_flag_write_i)
     , .flags_o(flags_o), .wb_o(wb_o));

  pj_backend_checker i_checker
    (.clk_i(clk_i), .reset_i(reset_i)
     , .push_i(push_i), .op_i(op_i), .full_i(full_o)
     , .rob_flag_i(rob_flag_i), .rob_flag_write_i(rob_flag_write_i)
     , .wb_i(wb_o), .wb_known_o(wb_known), .wb_exp_data_o(wb_exp_data)
     , .model_flags_o(model_flags), .outstanding_o(outstanding)
     , .full_exp_o(full_exp), .full_obs_o(full_obs));

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_value(string what, logic [31:0] exp, logic [31:0] act);
    $display("** Error %s %s: expected %h actual %h", test_name, what, exp, act);
    $display("TESTS FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_plain(string msg);
    $display("%s: %s", test_name, msg);
    $display("TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_wb(int port, logic known, pj_reg_pkg::word_t exp,
    pj_reg_pkg::word_t act);
    if (!known)
      report_plain($sformatf("write-back on port %0d matches no pushed operation", port));
    else
      report_value($sformatf("wb_o[%0d] data", port), exp, act);
  endtask

  a_wb_alu: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_o[0].valid |-> (wb_known[0] && (wb_o[0].data == wb_exp_data[0])))
    else check_wb(0, $sampled(wb_known[0]), $sampled(wb_exp_data[0]),
                  $sampled(wb_o[0].data));

  a_wb_mul: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_o[1].valid |-> (wb_known[1] && (wb_o[1].data == wb_exp_data[1])))
    else check_wb(1, $sampled(wb_known[1]), $sampled(wb_exp_data[1]),
                  $sampled(wb_o[1].data));

  a_flags: assert property (@(posedge clk_i) disable iff (reset_i)
    flags_o == model_flags)
    else report_value("flags_o", 32'($sampled(model_flags)), 32'($sampled(flags_o)));

  // delayed full_o against the queue count rebuilt from write-backs
  a_full: assert property (@(posedge clk_i) disable iff (reset_i)
    full_obs == full_exp)
    else report_value("full_o", 32'($sampled(full_exp)), 32'($sampled(full_obs)));

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles in %s", cycle_count, test_name);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  always @(negedge clk_i)
  begin
    if (!reset_i && full_o)
      saw_full <= 1'b1;
  end

  function automatic int rand_below(int n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic pj_reg_pkg::phys_tag_t alloc_tag();
    pj_reg_pkg::phys_tag_t t;
    t = free_q.pop_front();
    known_q.push_back(t);
    alloc_q.push_back(t);
    return t;
  endfunction

  task automatic push_op(pj_op_pkg::alu_op_e op, pj_reg_pkg::phys_tag_t dst,
    pj_reg_pkg::phys_tag_t src1, pj_reg_pkg::phys_tag_t src2, pj_reg_pkg::word_t imm);
    @(negedge clk_i);
    while (full_o)
      @(negedge clk_i);
    @(posedge clk_i);
    push_i <= 1'b1;
    op_i   <= '{op: op, dst: dst, src1: src1, src2: src2, imm: imm};
    @(posedge clk_i);
    push_i <= 1'b0;
  endtask

  task automatic drain();
    @(negedge clk_i);
    while (outstanding != 0)
      @(negedge clk_i);
  endtask

  task automatic free_random();
    int                    idx;
    pj_reg_pkg::phys_tag_t t;
    idx = rand_below(alloc_q.size());
    t   = alloc_q[idx];
    alloc_q.delete(idx);
    for (int i = 0; i < known_q.size(); i++)
    begin
      if (known_q[i] == t)
      begin
        known_q.delete(i);
        break;
      end
    end
    @(posedge clk_i);
    rob_free_i     <= 1'b1;
    rob_free_tag_i <= t;
    @(posedge clk_i);
    rob_free_i <= 1'b0;
    free_q.push_back(t);
  endtask

  task automatic write_flags();
    @(posedge clk_i);
    rob_flag_i       <= 1'b1;
    rob_flag_write_i <= pj_reg_pkg::flag_write_t'(8'(rand_below(256)));
    @(posedge clk_i);
    rob_flag_i <= 1'b0;
  endtask

  task automatic push_random();
    pj_op_pkg::alu_op_e op;
    case (rand_below(6))
      0:       op = pj_op_pkg::OP_ADD;
      1:       op = pj_op_pkg::OP_SUB;
      2:       op = pj_op_pkg::OP_AND;
      3:       op = pj_op_pkg::OP_OR;
      4:       op = pj_op_pkg::OP_ADDI;
      default: op = pj_op_pkg::OP_MUL;
    endcase
    // pick sources before the new dst joins the known tags
    push_op(op, free_q[0], known_q[rand_below(known_q.size())],
            known_q[rand_below(known_q.size())], pj_reg_pkg::word_t'($random(seed)));
    void'(alloc_tag());
  endtask

  initial
  begin
    pj_reg_pkg::phys_tag_t a, b, p, q, r;
    pj_reg_pkg::phys_tag_t m1, m2, m3;
    seed             = 95074;
    cycle_count      = 0;
    saw_full         = 1'b0;
    reset_i          = 1'b1;
    push_i           = 1'b0;
    op_i             = '0;
    rob_free_i       = 1'b0;
    rob_free_tag_i   = '0;
    rob_flag_i       = 1'b0;
    rob_flag_write_i = '0;
    test_name        = "reset_values";
    for (int t = `PJ_RESET_VALID; t < `PJ_NUM_PHYS_REG; t++)
      free_q.push_back(pj_reg_pkg::phys_tag_t'(t));
    for (int t = 0; t < `PJ_RESET_VALID; t++)
      known_q.push_back(pj_reg_pkg::phys_tag_t'(t));
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (wb_o[0].valid || wb_o[1].valid || full_o || (flags_o != '0))
      report_plain("outputs not idle after reset");

    test_name = "addi_from_reset_tag";
    a = alloc_tag();
    push_op(pj_op_pkg::OP_ADDI, a, 6'd3, 6'd3, 32'h0000_1234);
    b = alloc_tag();
    push_op(pj_op_pkg::OP_ADDI, b, 6'd4, 6'd4, 32'h0001_0007);
    drain();

    test_name = "dependent_chain";
    p = alloc_tag();
    push_op(pj_op_pkg::OP_MUL, p, a, b, '0);
    q = alloc_tag();
    push_op(pj_op_pkg::OP_ADD, q, p, a, '0);
    r = alloc_tag();
    push_op(pj_op_pkg::OP_ADD, r, q, q, '0);
    drain();

    // a three-deep multiply chain keeps the add at the head blocked
    test_name = "queue_fill";
    m1 = alloc_tag();
    push_op(pj_op_pkg::OP_MUL, m1, a, b, '0);
    m2 = alloc_tag();
    push_op(pj_op_pkg::OP_MUL, m2, m1, m1, '0);
    m3 = alloc_tag();
    push_op(pj_op_pkg::OP_MUL, m3, m2, a, '0);
    push_op(pj_op_pkg::OP_ADD, alloc_tag(), m3, a, '0);
    push_op(pj_op_pkg::OP_ADDI, alloc_tag(), 6'd5, 6'd5, 32'h0000_00ff);
    push_op(pj_op_pkg::OP_OR, alloc_tag(), a, b, '0);
    push_op(pj_op_pkg::OP_SUB, alloc_tag(), b, a, '0);
    push_op(pj_op_pkg::OP_AND, alloc_tag(), a, r, '0);
    drain();

    test_name = "random_rounds";
    for (int rnd = 0; rnd < ROUNDS; rnd++)
    begin
      for (int k = 0; k < OPS_PER_ROUND; k++)
        push_random();
      drain();
      repeat (3) write_flags();
      // tags freed here come back as destinations in later rounds
      repeat (6) free_random();
    end
    drain();

    if (!saw_full)
    begin
      $display("full_o never rose while the queue was blocked");
      $display("TESTS FAILED");
      $fatal(1, "queue never filled");
    end
    else
    begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- hw/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
  (input  logic                    clk_i
   , input  logic                  reset_i
   , input  pj_op_pkg::issued_op_t issue_i
   , input  logic                  issue_v_i
   , output pj_op_pkg::wb_t        wb_o
   );

  pj_reg_pkg::word_t     result;
  logic                  wb_valid_q;
  pj_reg_pkg::phys_tag_t wb_tag_q;
  pj_reg_pkg::word_t     wb_data_q;

  always_comb
  begin
    case (issue_i.op)
      pj_op_pkg::OP_ADD,
      pj_op_pkg::OP_ADDI: result = issue_i.operand_a + issue_i.operand_b;
      pj_op_pkg::OP_SUB:  result = issue_i.operand_a - issue_i.operand_b;
      pj_op_pkg::OP_AND:  result = issue_i.operand_a & issue_i.operand_b;
      pj_op_pkg::OP_OR:   result = issue_i.operand_a | issue_i.operand_b;
      // multiplies never reach this unit
      default:            result = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      wb_valid_q <= 1'b0;
    else
      wb_valid_q <= issue_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_v_i)
    begin
      wb_tag_q  <= issue_i.dst;
      wb_data_q <= result;
    end
  end

  assign wb_o = '{valid: wb_valid_q, tag: wb_tag_q, data: wb_data_q};

endmodule

//--- hw/arch_state.sv
`timescale 1ns/1ps
`include "pj_cfg.svh"

module arch_state
  (input  logic                                    clk_i
   , input  logic                                  reset_i
   // write-back from the function units
   , input  pj_op_pkg::wb_t [`PJ_NUM_FU-1:0]       exe_wb_i
   // register free from commit
   , input  logic                                  rob_free_i
   , input  pj_reg_pkg::phys_tag_t                 rob_free_tag_i
   // flag update from commit
   , input  logic                                  rob_flag_i
   , input  pj_reg_pkg::flag_write_t               rob_flag_write_i
   , output pj_reg_pkg::flags_t                    flags_o
   // issue read ports
   , input  pj_reg_pkg::phys_tag_t                 rs1_tag_i
   , input  pj_reg_pkg::phys_tag_t                 rs2_tag_i
   , output logic                                  rs1_valid_o
   , output logic                                  rs2_valid_o
   , output pj_reg_pkg::word_t                     rs1_data_o
   , output pj_reg_pkg::word_t                     rs2_data_o
   );

  localparam int NUM_REG = `PJ_NUM_PHYS_REG;
  localparam int NUM_FU  = `PJ_NUM_FU;

  // low tags start out valid, the rest wait for a producer
  localparam logic [NUM_REG-1:0] RESET_VALID_MASK =
    (NUM_REG'(1) << `PJ_RESET_VALID) - NUM_REG'(1);

  pj_reg_pkg::word_t [NUM_REG-1:0] data_q;
  pj_reg_pkg::word_t [NUM_REG-1:0] data_n;
  logic [NUM_REG-1:0]              valid_q;
  logic [NUM_REG-1:0]              valid_n;
  pj_reg_pkg::flags_t              flags_q;
  pj_reg_pkg::flags_t              flags_n;

  function automatic logic wb_tag_clash(pj_op_pkg::wb_t [NUM_FU-1:0] wb);
    logic clash;
    clash = 1'b0;
    for (int i = 0; i < NUM_FU; i++)
    begin
      for (int j = i + 1; j < NUM_FU; j++)
      begin
        if (wb[i].valid && wb[j].valid && (wb[i].tag == wb[j].tag))
          clash = 1'b1;
      end
    end
    return clash;
  endfunction

  // reads see this cycle's write-backs ahead of the array
  always_comb
  begin
    rs1_valid_o = valid_q[rs1_tag_i];
    rs1_data_o  = data_q[rs1_tag_i];
    rs2_valid_o = valid_q[rs2_tag_i];
    rs2_data_o  = data_q[rs2_tag_i];
    for (int i = 0; i < NUM_FU; i++)
    begin
      if (exe_wb_i[i].valid && (exe_wb_i[i].tag == rs1_tag_i))
      begin
        rs1_valid_o = 1'b1;
        rs1_data_o  = exe_wb_i[i].data;
      end
      if (exe_wb_i[i].valid && (exe_wb_i[i].tag == rs2_tag_i))
      begin
        rs2_valid_o = 1'b1;
        rs2_data_o  = exe_wb_i[i].data;
      end
    end
  end

  always_comb
  begin
    data_n  = data_q;
    valid_n = valid_q;
    for (int i = 0; i < NUM_FU; i++)
    begin
      if (exe_wb_i[i].valid)
      begin
        data_n[exe_wb_i[i].tag]  = exe_wb_i[i].data;
        valid_n[exe_wb_i[i].tag] = 1'b1;
      end
    end
    // free comes last so it beats a write-back to the same tag
    if (rob_free_i)
      valid_n[rob_free_tag_i] = 1'b0;
  end

  assign flags_n = rob_flag_i
                 ? ((rob_flag_write_i.keep_mask & flags_q)
                   | (~rob_flag_write_i.keep_mask & rob_flag_write_i.value))
                 : flags_q;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      data_q  <= '0;
      valid_q <= RESET_VALID_MASK;
      flags_q <= '0;
    end
    else
    begin
      data_q  <= data_n;
      valid_q <= valid_n;
      flags_q <= flags_n;
    end
  end

  assign flags_o = flags_q;

  // rename never gives two in-flight ops the same destination
  a_unique_wb_tag: assert property (@(posedge clk_i) disable iff (reset_i)
    !wb_tag_clash(exe_wb_i));

endmodule

//--- hw/issue_unit.sv
`timescale 1ns/1ps

module issue_unit
  (input  logic                     clk_i
   , input  logic                   reset_i
   // queue head
   , input  pj_op_pkg::renamed_op_t head_i
   , input  logic                   head_valid_i
   , output logic                   pop_o
   // register file read ports
   , output pj_reg_pkg::phys_tag_t  rs1_tag_o
   , output pj_reg_pkg::phys_tag_t  rs2_tag_o
   , input  logic                   rs1_valid_i
   , input  logic                   rs2_valid_i
   , input  pj_reg_pkg::word_t      rs1_data_i
   , input  pj_reg_pkg::word_t      rs2_data_i
   // dispatch to the function units
   , output pj_op_pkg::issued_op_t  alu_issue_o
   , output pj_op_pkg::issued_op_t  mul_issue_o
   , output logic                   alu_issue_v_o
   , output logic                   mul_issue_v_o
   );

  logic                  needs_rs2;
  logic                  ready;
  logic                  to_mul;
  pj_op_pkg::issued_op_t issue_d;
  pj_op_pkg::issued_op_t alu_q;
  pj_op_pkg::issued_op_t mul_q;
  logic                  alu_v_q;
  logic                  mul_v_q;

  assign rs1_tag_o = head_i.src1;
  assign rs2_tag_o = head_i.src2;

  // addi takes its second operand from the immediate
  assign needs_rs2 = (head_i.op != pj_op_pkg::OP_ADDI);
  assign ready     = head_valid_i && rs1_valid_i && (rs2_valid_i || !needs_rs2);
  assign to_mul    = (head_i.op == pj_op_pkg::OP_MUL);
  assign pop_o     = ready;

  always_comb
  begin
    issue_d.op        = head_i.op;
    issue_d.dst       = head_i.dst;
    issue_d.operand_a = rs1_data_i;
    issue_d.operand_b = needs_rs2 ? rs2_data_i : head_i.imm;
  end

  always_ff @(posedge clk_i)
  begin
    if (ready && !to_mul)
      alu_q <= issue_d;
    if (ready && to_mul)
      mul_q <= issue_d;
  end

  // one op per edge, steered by opcode
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      alu_v_q <= 1'b0;
      mul_v_q <= 1'b0;
    end
    else
    begin
      alu_v_q <= ready && !to_mul;
      mul_v_q <= ready && to_mul;
    end
  end

  assign alu_issue_o   = alu_q;
  assign mul_issue_o   = mul_q;
  assign alu_issue_v_o = alu_v_q;
  assign mul_issue_v_o = mul_v_q;

endmodule

//--- hw/mul_unit.sv
`timescale 1ns/1ps
`include "pj_cfg.svh"

module mul_unit
  (input  logic                    clk_i
   , input  logic                  reset_i
   , input  pj_op_pkg::issued_op_t issue_i
   , input  logic                  issue_v_i
   , output pj_op_pkg::wb_t        wb_o
   );

  localparam int HALF = `PJ_WORD_SIZE / 2;

  typedef logic [HALF-1:0] half_t;

  half_t a_lo, a_hi, b_lo, b_hi;

  // per-stage occupancy, tag and opcode
  pj_op_pkg::mul_stage_e s1_st_q, s2_st_q, s3_st_q;
  pj_reg_pkg::phys_tag_t s1_tag_q, s2_tag_q, s3_tag_q;
  pj_op_pkg::alu_op_e    s1_op_q, s2_op_q, s3_op_q;

  // stage data
  pj_reg_pkg::word_t s1_ll_q;
  half_t             s1_hl_q;
  half_t             s1_lh_q;
  pj_reg_pkg::word_t s2_ll_q;
  half_t             s2_cross_q;
  pj_reg_pkg::word_t s3_data_q;

  assign a_lo = issue_i.operand_a[HALF-1:0];
  assign a_hi = issue_i.operand_a[2*HALF-1:HALF];
  assign b_lo = issue_i.operand_b[HALF-1:0];
  assign b_hi = issue_i.operand_b[2*HALF-1:HALF];

  always_ff @(posedge clk_i)
  begin
    // stage 1, partial products, only the low half of the cross terms matters
    s1_ll_q    <= pj_reg_pkg::word_t'(a_lo) * pj_reg_pkg::word_t'(b_lo);
    s1_hl_q    <= a_hi * b_lo;
    s1_lh_q    <= a_lo * b_hi;
    s1_tag_q   <= issue_i.dst;
    s1_op_q    <= issue_i.op;
    // stage 2, fold the cross terms
    s2_ll_q    <= s1_ll_q;
    s2_cross_q <= s1_hl_q + s1_lh_q;
    s2_tag_q   <= s1_tag_q;
    s2_op_q    <= s1_op_q;
    // stage 3, final low-word sum
    s3_data_q  <= s2_ll_q + {s2_cross_q, {HALF{1'b0}}};
    s3_tag_q   <= s2_tag_q;
    s3_op_q    <= s2_op_q;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      s1_st_q <= pj_op_pkg::MUL_STG_EMPTY;
      s2_st_q <= pj_op_pkg::MUL_STG_EMPTY;
      s3_st_q <= pj_op_pkg::MUL_STG_EMPTY;
    end
    else
    begin
      s1_st_q <= issue_v_i ? pj_op_pkg::MUL_STG_BUSY : pj_op_pkg::MUL_STG_EMPTY;
      s2_st_q <= s1_st_q;
      s3_st_q <= s2_st_q;
    end
  end

  assign wb_o = '{valid: (s3_st_q == pj_op_pkg::MUL_STG_BUSY),
                  tag:   s3_tag_q,
                  data:  s3_data_q};

  // issue only steers multiplies here
  a_mul_only: assert property (@(posedge clk_i) disable iff (reset_i)
    ((s1_st_q != pj_op_pkg::MUL_STG_BUSY) || (s1_op_q == pj_op_pkg::OP_MUL))
    && ((s2_st_q != pj_op_pkg::MUL_STG_BUSY) || (s2_op_q == pj_op_pkg::OP_MUL))
    && ((s3_st_q != pj_op_pkg::MUL_STG_BUSY) || (s3_op_q == pj_op_pkg::OP_MUL)));

endmodule

//--- hw/op_queue.sv
`timescale 1ns/1ps
`include "pj_cfg.svh"

module op_queue
  (input  logic                     clk_i
   , input  logic                   reset_i
   // producer side
   , input  logic                   push_i
   , input  pj_op_pkg::renamed_op_t op_i
   // issue side
   , input  logic                   pop_i
   , output pj_op_pkg::renamed_op_t head_o
   , output logic                   head_valid_o
   , output logic                   full_o
   );

  localparam int DEPTH = `PJ_IQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  pj_op_pkg::renamed_op_t mem_q [DEPTH];
  ptr_t                   wr_ptr_q;
  ptr_t                   rd_ptr_q;
  cnt_t                   count_q;

  // wrap at depth, which need not be a power of two
  function automatic ptr_t ptr_next(ptr_t p);
    if (p == ptr_t'(DEPTH - 1))
      return '0;
    return p + ptr_t'(1);
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= op_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop_i)
        rd_ptr_q <= ptr_next(rd_ptr_q);
      // simultaneous push and pop leaves the count alone
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o       = mem_q[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  assign full_o       = (count_q == cnt_t'(DEPTH));

  // producer respects full_o, issue only pops a valid head
  a_queue_bounds: assert property (@(posedge clk_i) disable iff (reset_i)
    !(push_i && full_o) && !(pop_i && !head_valid_o));

endmodule

//--- hw/pj_backend.sv
`timescale 1ns/1ps
`include "pj_cfg.svh"

module pj_backend
  (input  logic                              clk_i
   , input  logic                            reset_i
   // renamed ops in
   , input  logic                            push_i
   , input  pj_op_pkg::renamed_op_t          op_i
   , output logic                            full_o
   // commit side
   , input  logic                            rob_free_i
   , input  pj_reg_pkg::phys_tag_t           rob_free_tag_i
   , input  logic                            rob_flag_i
   , input  pj_reg_pkg::flag_write_t         rob_flag_write_i
   , output pj_reg_pkg::flags_t              flags_o
   // write-back, 0 is the alu and 1 the multiplier
   , output pj_op_pkg::wb_t [`PJ_NUM_FU-1:0] wb_o
   );

  pj_op_pkg::renamed_op_t head_op;
  logic                   head_valid;
  logic                   pop;
  pj_reg_pkg::phys_tag_t  rs1_tag;
  pj_reg_pkg::phys_tag_t  rs2_tag;
  logic                   rs1_valid;
  logic                   rs2_valid;
  pj_reg_pkg::word_t      rs1_data;
  pj_reg_pkg::word_t      rs2_data;
  pj_op_pkg::issued_op_t  alu_issue;
  pj_op_pkg::issued_op_t  mul_issue;
  logic                   alu_issue_v;
  logic                   mul_issue_v;

  op_queue i_op_queue
    (.clk_i(clk_i), .reset_i(reset_i)
     , .push_i(push_i), .op_i(op_i)
     , .pop_i(pop), .head_o(head_op), .head_valid_o(head_valid)
     , .full_o(full_o));

  issue_unit i_issue_unit
    (.clk_i(clk_i), .reset_i(reset_i)
     , .head_i(head_op), .head_valid_i(head_valid), .pop_o(pop)
     , .rs1_tag_o(rs1_tag), .rs2_tag_o(rs2_tag)
     , .rs1_valid_i(rs1_valid), .rs2_valid_i(rs2_valid)
     , .rs1_data_i(rs1_data), .rs2_data_i(rs2_data)
     , .alu_issue_o(alu_issue), .mul_issue_o(mul_issue)
     , .alu_issue_v_o(alu_issue_v), .mul_issue_v_o(mul_issue_v));

  alu_unit i_alu_unit
    (.clk_i(clk_i), .reset_i(reset_i)
     , .issue_i(alu_issue), .issue_v_i(alu_issue_v)
     , .wb_o(wb_o[0]));

  mul_unit i_mul_unit
    (.clk_i(clk_i), .reset_i(reset_i)
     , .issue_i(mul_issue), .issue_v_i(mul_issue_v)
     , .wb_o(wb_o[1]));

  arch_state i_arch_state
    (.clk_i(clk_i), .reset_i(reset_i)
     , .exe_wb_i(wb_o)
     , .rob_free_i(rob_free_i), .rob_free_tag_i(rob_free_tag_i)
     , .rob_flag_i(rob_flag_i), .rob_flag_write_i(rob_flag_write_i)
     , .flags_o(flags_o)
     , .rs1_tag_i(rs1_tag), .rs2_tag_i(rs2_tag)
     , .rs1_valid_o(rs1_valid), .rs2_valid_o(rs2_valid)
     , .rs1_data_o(rs1_data), .rs2_data_o(rs2_data));

endmodule

//--- hw/pj_op_pkg.sv
package pj_op_pkg;

  // opcodes, OP_MUL goes to the multiplier and the rest to the alu
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_ADDI = 3'd4,
    OP_MUL  = 3'd5
  } alu_op_e;

  // operation as it leaves rename
  typedef struct packed {
    alu_op_e               op;
    pj_reg_pkg::phys_tag_t dst;
    pj_reg_pkg::phys_tag_t src1;
    pj_reg_pkg::phys_tag_t src2;
    pj_reg_pkg::word_t     imm;
  } renamed_op_t;

  // operation with its operands already read
  typedef struct packed {
    alu_op_e               op;
    pj_reg_pkg::phys_tag_t dst;
    pj_reg_pkg::word_t     operand_a;
    pj_reg_pkg::word_t     operand_b;
  } issued_op_t;

  // result of one function unit
  typedef struct packed {
    logic                  valid;
    pj_reg_pkg::phys_tag_t tag;
    pj_reg_pkg::word_t     data;
  } wb_t;

  // occupancy of one multiplier stage
  typedef enum logic {
    MUL_STG_EMPTY = 1'b0,
    MUL_STG_BUSY  = 1'b1
  } mul_stage_e;

endpackage

//--- hw/pj_reg_pkg.sv
`include "pj_cfg.svh"

package pj_reg_pkg;

  // physical register tag
  typedef logic [$clog2(`PJ_NUM_PHYS_REG)-1:0] phys_tag_t;

  // one data word of the register file
  typedef logic [`PJ_WORD_SIZE-1:0] word_t;

  // condition flag vector
  typedef logic [`PJ_NUM_FLAGS-1:0] flags_t;

  // masked flag update from commit
  // a set keep_mask bit holds the old flag, a clear bit takes value
  typedef struct packed {
    flags_t keep_mask;
    flags_t value;
  } flag_write_t;

endpackage

//--- include/pj_cfg.svh
`ifndef PJ_CFG_SVH
`define PJ_CFG_SVH

// width of a data word
`define PJ_WORD_SIZE 32

// physical registers, tags are log2 of this wide
`define PJ_NUM_PHYS_REG 64

// write-back ports, 0 is the alu and 1 the multiplier
`define PJ_NUM_FU 2

// condition flags held by the commit side
`define PJ_NUM_FLAGS 4

// entries in the in-order op queue
`define PJ_IQ_DEPTH 4

// tags below this count come out of reset valid with data 0
`define PJ_RESET_VALID 16

`endif
